/* common/matmul_pkg.sv */
/*
 * Shared definitions of the matrix-multiply engine: block sizes,
 * vector types, the decoded weight control bits and the readout
 * FSM states.
 */
package matmul_pkg;

    // one block is four cycles and feeds four activation columns
    localparam int slices = 4;
    localparam int weights_per_byte = 3;
    localparam int rows = weights_per_byte * slices;
    localparam int queue_len = rows * slices;

    localparam int acc_width = 18;
    // lowest accumulator bit seen on the output byte
    localparam int out_lsb = 9;

    // mixed radix packing of a weight byte
    localparam int radix_first = 5;
    localparam int radix_rest = 7;
    localparam int weight_codes = radix_first * radix_rest * radix_rest;

    typedef logic [1:0] slice_t;
    typedef logic [7:0] wbyte_t;
    typedef logic signed [7:0] act_t;
    typedef logic signed [acc_width-1:0] acc_t;
    typedef logic [5:0] qidx_t;

    // one decoded weight
    typedef struct packed {
        logic zero;
        logic sign;
        logic mul2;
        logic div2;
    } weight_ctl_t;

    localparam weight_ctl_t weight_none = '{zero: 1'b1, sign: 1'b0, mul2: 1'b0, div2: 1'b0};

    typedef enum logic [2:0] {
        idle,
        drain,
        capture,
        ack_wait,
        stream
    } readout_state_t;

endpackage

/* rtl/weight_unpack.sv */
/*
 * Weight unpacker. Splits one packed byte into a base-5 digit and
 * two base-7 digits and turns each into zero/sign/mul2/div2 bits.
 */
module weight_unpack (
    input  matmul_pkg::wbyte_t packed_byte,
    output matmul_pkg::weight_ctl_t [matmul_pkg::weights_per_byte-1:0] weights
);

    matmul_pkg::wbyte_t upper;
    logic [2:0] digit_first;
    logic [2:0] digit_mid;
    logic [2:0] digit_last;

    // first digit: 0, 1, 2, -1, -2
    function automatic matmul_pkg::weight_ctl_t decode_first(input logic [2:0] digit);
        matmul_pkg::weight_ctl_t w;
        case (digit)
            3'd1: w = '{zero: 1'b0, sign: 1'b0, mul2: 1'b0, div2: 1'b0};
            3'd2: w = '{zero: 1'b0, sign: 1'b0, mul2: 1'b1, div2: 1'b0};
            3'd3: w = '{zero: 1'b0, sign: 1'b1, mul2: 1'b0, div2: 1'b0};
            3'd4: w = '{zero: 1'b0, sign: 1'b1, mul2: 1'b1, div2: 1'b0};
            default: w = matmul_pkg::weight_none;
        endcase
        return w;
    endfunction

    // other digits: 0, 0.5, 1, 2, -0.5, -1, -2
    function automatic matmul_pkg::weight_ctl_t decode_rest(input logic [2:0] digit);
        matmul_pkg::weight_ctl_t w;
        case (digit)
            3'd1: w = '{zero: 1'b0, sign: 1'b0, mul2: 1'b0, div2: 1'b1};
            3'd2: w = '{zero: 1'b0, sign: 1'b0, mul2: 1'b0, div2: 1'b0};
            3'd3: w = '{zero: 1'b0, sign: 1'b0, mul2: 1'b1, div2: 1'b0};
            3'd4: w = '{zero: 1'b0, sign: 1'b1, mul2: 1'b0, div2: 1'b1};
            3'd5: w = '{zero: 1'b0, sign: 1'b1, mul2: 1'b0, div2: 1'b0};
            3'd6: w = '{zero: 1'b0, sign: 1'b1, mul2: 1'b1, div2: 1'b0};
            default: w = matmul_pkg::weight_none;
        endcase
        return w;
    endfunction

    assign upper = packed_byte / matmul_pkg::wbyte_t'(matmul_pkg::radix_first);
    assign digit_first = 3'(packed_byte % matmul_pkg::wbyte_t'(matmul_pkg::radix_first));
    assign digit_mid = 3'(upper % matmul_pkg::wbyte_t'(matmul_pkg::radix_rest));
    assign digit_last = 3'(upper / matmul_pkg::wbyte_t'(matmul_pkg::radix_rest));

    always_comb begin
        if (packed_byte >= matmul_pkg::wbyte_t'(matmul_pkg::weight_codes)) begin
            // unused codes carry no weight
            weights = {matmul_pkg::weights_per_byte{matmul_pkg::weight_none}};
        end else begin
            weights[0] = decode_first(digit_first);
            weights[1] = decode_rest(digit_mid);
            weights[2] = decode_rest(digit_last);
        end
    end

endmodule

/* array/operand_buffer.sv */
/*
 * Operand double buffer. Weight triplets and activations shift into
 * load registers every cycle; at the end of a block the load side is
 * copied to the current side that feeds the MAC array.
 */
module operand_buffer (
    input  logic clk,
    input  logic reset,
    input  matmul_pkg::weight_ctl_t [matmul_pkg::weights_per_byte-1:0] weights_in,
    input  matmul_pkg::act_t act_in,
    input  logic flush,
    input  matmul_pkg::slice_t slice,
    output matmul_pkg::weight_ctl_t [matmul_pkg::rows-1:0] weights_cur,
    output matmul_pkg::act_t act_cur
);

    matmul_pkg::weight_ctl_t [matmul_pkg::rows-1:0] weights_load;
    matmul_pkg::weight_ctl_t [matmul_pkg::rows-1:0] weights_next;
    matmul_pkg::act_t [matmul_pkg::slices-1:0] acts_load;
    matmul_pkg::act_t [matmul_pkg::slices-1:0] acts_next;
    matmul_pkg::act_t [matmul_pkg::slices-1:0] acts_cur;

    // newest byte enters at the top, so byte k ends up in rows 3k..3k+2
    assign weights_next = {weights_in,
                           weights_load[matmul_pkg::rows-1:matmul_pkg::weights_per_byte]};
    assign acts_next = {act_in, acts_load[matmul_pkg::slices-1:1]};

    always_ff @(posedge clk) begin
        weights_load <= weights_next;
        acts_load <= acts_next;
    end

    // flush copies the load side including the byte of the last slice
    always_ff @(posedge clk) begin
        if (reset) begin
            weights_cur <= {matmul_pkg::rows{matmul_pkg::weight_none}};
        end else if (flush) begin
            weights_cur <= weights_next;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            acts_cur <= acts_next;
        end
    end

    // column j is consumed during slice j
    assign act_cur = acts_cur[slice];

    for (genvar k = 0; k < matmul_pkg::weights_per_byte; k++) begin : g_check
        // a decoded zero weight never asks for both shifts
        assert property (@(posedge clk) disable iff (reset)
            weights_in[k].zero |-> !(weights_in[k].mul2 && weights_in[k].div2))
        else $error("weight %0d decoded with zero, mul2 and div2 set", k);
    end

endmodule

/* array/mac_array.sv */
/*
 * Shift/add MAC array. Each of the twelve rows scales the current
 * activation by its weight and adds the result into the accumulator
 * of that row and the current column.
 */
module mac_array (
    input  logic clk,
    input  logic reset,
    input  matmul_pkg::weight_ctl_t [matmul_pkg::rows-1:0] weights_cur,
    input  matmul_pkg::act_t act_cur,
    input  matmul_pkg::slice_t slice,
    input  logic acc_clear,
    output matmul_pkg::acc_t [matmul_pkg::queue_len-1:0] acc
);

    matmul_pkg::acc_t act_x1;
    matmul_pkg::acc_t act_x2;
    matmul_pkg::acc_t act_half;
    matmul_pkg::acc_t [matmul_pkg::rows-1:0] term;
    matmul_pkg::acc_t [matmul_pkg::queue_len-1:0] acc_next;

    // shifted copies of the activation are shared by all rows
    assign act_x1 = matmul_pkg::acc_t'(act_cur);
    assign act_x2 = act_x1 <<< 1;
    assign act_half = act_x1 >>> 1;

    always_comb begin
        matmul_pkg::acc_t magnitude;
        for (int r = 0; r < matmul_pkg::rows; r++) begin
            if (weights_cur[r].mul2) begin
                magnitude = act_x2;
            end else if (weights_cur[r].div2) begin
                magnitude = act_half;
            end else begin
                magnitude = act_x1;
            end

            if (weights_cur[r].zero) begin
                term[r] = '0;
            end else if (weights_cur[r].sign) begin
                term[r] = -magnitude;
            end else begin
                term[r] = magnitude;
            end
        end
    end

    // only the column of the current slice takes the term
    always_comb begin
        matmul_pkg::acc_t base;
        for (int r = 0; r < matmul_pkg::rows; r++) begin
            for (int c = 0; c < matmul_pkg::slices; c++) begin
                // a clear restarts the sum from zero on the same edge
                base = acc_clear ? '0 : acc[r * matmul_pkg::slices + c];
                if (slice == matmul_pkg::slice_t'(c)) begin
                    acc_next[r * matmul_pkg::slices + c] = base + term[r];
                end else begin
                    acc_next[r * matmul_pkg::slices + c] = base;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

endmodule

/* array/result_queue.sv */
/*
 * Result queue. Takes a snapshot of all accumulators and shifts it
 * out one byte per cycle, row by row and column by column.
 */
module result_queue (
    input  logic clk,
    input  logic reset,
    input  logic capture,
    input  matmul_pkg::acc_t [matmul_pkg::queue_len-1:0] acc,
    output logic [7:0] out_data,
    output logic out_valid,
    output logic stream_done
);

    matmul_pkg::acc_t [matmul_pkg::queue_len-1:0] queue;
    matmul_pkg::qidx_t count;

    always_ff @(posedge clk) begin
        if (capture) begin
            queue <= acc;
        end else if (out_valid) begin
            queue <= {queue[matmul_pkg::queue_len-1], queue[matmul_pkg::queue_len-1:1]};
        end
    end

    // one idle cycle after capture, then queue_len valid cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            out_valid <= 1'b0;
            stream_done <= 1'b0;
        end else if (capture) begin
            count <= matmul_pkg::qidx_t'(matmul_pkg::queue_len);
            out_valid <= 1'b0;
            stream_done <= 1'b0;
        end else if (out_valid) begin
            count <= count - 1'b1;
            if (count == matmul_pkg::qidx_t'(1)) begin
                out_valid <= 1'b0;
                stream_done <= 1'b1;
            end
        end else if (count != '0) begin
            out_valid <= 1'b1;
        end
    end

    // bits 16..9 of the head entry
    assign out_data = queue[0][matmul_pkg::out_lsb +: 8];

    // the controller holds off a new readout until streaming is over
    assert property (@(posedge clk) disable iff (reset) capture |-> !out_valid)
    else $error("capture arrived during an output stream");

endmodule

/* rtl/readout_ctrl.sv */
/*
 * Readout controller. Runs the block slice counter and the readout
 * FSM with the four-phase read_req/read_ack handshake.
 */
module readout_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic read_req,
    output logic read_ack,
    input  logic stream_done,
    output matmul_pkg::slice_t slice,
    output logic flush,
    output logic acc_clear,
    output logic capture
);

    matmul_pkg::readout_state_t state;
    matmul_pkg::readout_state_t state_next;
    // one block end already seen while draining
    logic end_seen;

    assign flush = (slice == matmul_pkg::slice_t'(matmul_pkg::slices - 1));
    assign capture = (state == matmul_pkg::capture);
    assign acc_clear = capture;
    assign read_ack = (state == matmul_pkg::ack_wait);

    // a new block starts right after the capture edge
    always_ff @(posedge clk) begin
        if (reset || capture) begin
            slice <= '0;
        end else begin
            slice <= slice + 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            matmul_pkg::idle: begin
                if (read_req) begin
                    state_next = matmul_pkg::drain;
                end
            end
            matmul_pkg::drain: begin
                // wait for the last block to be loaded and then computed
                if (flush && end_seen) begin
                    state_next = matmul_pkg::capture;
                end
            end
            matmul_pkg::capture: begin
                state_next = matmul_pkg::ack_wait;
            end
            matmul_pkg::ack_wait: begin
                if (!read_req) begin
                    state_next = matmul_pkg::stream;
                end
            end
            matmul_pkg::stream: begin
                if (stream_done) begin
                    state_next = matmul_pkg::idle;
                end
            end
            default: begin
                state_next = matmul_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= matmul_pkg::idle;
            end_seen <= 1'b0;
        end else begin
            state <= state_next;
            // the block end of the request cycle already counts
            if (state == matmul_pkg::idle) begin
                end_seen <= flush;
            end else if (state == matmul_pkg::drain && flush) begin
                end_seen <= 1'b1;
            end
        end
    end

    // the host may drop read_req as soon as it sees read_ack
    assert property (@(posedge clk) disable iff (reset) $rose(read_ack) |-> $past(read_req))
    else $error("read_ack raised without read_req");

    assert property (@(posedge clk) disable iff (reset) capture |=> !capture)
    else $error("capture held longer than one cycle");

endmodule

/* rtl/matmul_top.sv */
/*
 * Top level of the packed-weight matrix-multiply engine. Connects
 * the weight unpacker, the operand buffer, the MAC array, the result
 * queue and the readout controller.
 */
module matmul_top (
    input  logic clk,
    input  logic reset,
    input  matmul_pkg::wbyte_t weight_in,
    input  matmul_pkg::act_t act_in,
    input  logic read_req,
    output logic read_ack,
    output logic [7:0] out_data,
    output logic out_valid
);

    matmul_pkg::weight_ctl_t [matmul_pkg::weights_per_byte-1:0] weights_dec;
    matmul_pkg::weight_ctl_t [matmul_pkg::rows-1:0] weights_cur;
    matmul_pkg::act_t act_cur;
    matmul_pkg::slice_t slice;
    matmul_pkg::acc_t [matmul_pkg::queue_len-1:0] acc;
    logic flush;
    logic acc_clear;
    logic capture;
    logic stream_done;

    weight_unpack u_unpack (
        .packed_byte (weight_in),
        .weights     (weights_dec)
    );

    operand_buffer u_operands (
        .clk         (clk),
        .reset       (reset),
        .weights_in  (weights_dec),
        .act_in      (act_in),
        .flush       (flush),
        .slice       (slice),
        .weights_cur (weights_cur),
        .act_cur     (act_cur)
    );

    mac_array u_mac (
        .clk         (clk),
        .reset       (reset),
        .weights_cur (weights_cur),
        .act_cur     (act_cur),
        .slice       (slice),
        .acc_clear   (acc_clear),
        .acc         (acc)
    );

    result_queue u_queue (
        .clk         (clk),
        .reset       (reset),
        .capture     (capture),
        .acc         (acc),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .stream_done (stream_done)
    );

    readout_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .read_req    (read_req),
        .read_ack    (read_ack),
        .stream_done (stream_done),
        .slice       (slice),
        .flush       (flush),
        .acc_clear   (acc_clear),
        .capture     (capture)
    );

endmodule

/* bench/matmul_tb.sv */
/*
 * Testbench of the packed-weight matrix-multiply engine. Sends blocks
 * from a table of tests, reads the accumulators back with read_req/read_ack
 * and compares every output byte with a shift/add reference model.
 */
module matmul_tb;

    localparam int num_tests = 7;
    // weight byte modes
    localparam int w_fixed = 0;
    localparam int w_rand = 1;
    localparam int w_high = 2;
    // activation modes
    localparam int a_fixed = 0;
    localparam int a_rand = 1;
    localparam int a_odd = 2;
    localparam int a_col0 = 3;

    typedef struct packed {
        int w_mode;
        int w_val;
        int a_mode;
        int a_val;
        int blocks;
        int first_byte;
    } test_t;

    logic clk;
    logic reset;
    matmul_pkg::wbyte_t weight_in;
    matmul_pkg::act_t act_in;
    logic read_req;
    logic read_ack;
    logic [7:0] out_data;
    logic out_valid;

    test_t tests [num_tests];
    int test_count;
    int model [matmul_pkg::rows][matmul_pkg::slices];
    logic [7:0] expect_q [$];
    int errors;
    int cycles;
    int cycle_limit;
    int ack_rise_cycle;
    int valid_run;
    int byte_index;
    logic prev_ack;
    logic prev_req;
    logic prev_valid;

    matmul_top uut (
        .clk       (clk),
        .reset     (reset),
        .weight_in (weight_in),
        .act_in    (act_in),
        .read_req  (read_req),
        .read_ack  (read_ack),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("error at time %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_test(input int w_mode, input int w_val, input int a_mode,
                            input int a_val, input int blocks, input int first_byte);
        test_t tc;
        tc.w_mode = w_mode;
        tc.w_val = w_val;
        tc.a_mode = a_mode;
        tc.a_val = a_val;
        tc.blocks = blocks;
        tc.first_byte = first_byte;
        tests[test_count] = tc;
        test_count++;
    endtask

    // weight in halves of one digit of a packed byte
    function automatic int weight_halves(input int code, input int pos);
        int digit;
        int halves;
        if (pos == 0) begin
            digit = code % 5;
        end else if (pos == 1) begin
            digit = (code / 5) % 7;
        end else begin
            digit = (code / 5) / 7;
        end
        halves = 0;
        if (code >= 245) begin
            halves = 0;
        end else if (pos == 0) begin
            case (digit)
                1: halves = 2;
                2: halves = 4;
                3: halves = -2;
                4: halves = -4;
                default: halves = 0;
            endcase
        end else begin
            case (digit)
                1: halves = 1;
                2: halves = 2;
                3: halves = 4;
                4: halves = -1;
                5: halves = -2;
                6: halves = -4;
                default: halves = 0;
            endcase
        end
        return halves;
    endfunction

    // half weights round toward minus infinity like an arithmetic shift
    function automatic int scaled_term(input int halves, input int act);
        int mag;
        int abs_h;
        abs_h = (halves < 0) ? -halves : halves;
        case (abs_h)
            1: mag = act >>> 1;
            2: mag = act;
            4: mag = act * 2;
            default: mag = 0;
        endcase
        return (halves < 0) ? -mag : mag;
    endfunction

    function automatic matmul_pkg::wbyte_t make_weight(input int mode, input int val);
        logic [31:0] word;
        case (mode)
            w_rand: word = $urandom;
            w_high: word = 32'd200 + ($urandom % 32'd56);
            default: word = val;
        endcase
        return word[7:0];
    endfunction

    function automatic matmul_pkg::act_t make_act(input int mode, input int val, input int col);
        logic [31:0] word;
        word = $urandom;
        if (mode == a_fixed || (mode == a_col0 && col == 0)) begin
            word = val;
        end else if (mode == a_odd) begin
            word[0] = 1'b1;
        end
        return word[7:0];
    endfunction

    // drives all blocks of one test and queues the bytes the model expects
    task automatic send_blocks(input test_t tc);
        matmul_pkg::wbyte_t blk_w [matmul_pkg::slices];
        matmul_pkg::act_t blk_a [matmul_pkg::slices];
        logic [31:0] word;
        int halves;
        for (int i = 0; i < matmul_pkg::rows; i++) begin
            for (int j = 0; j < matmul_pkg::slices; j++) begin
                model[i][j] = 0;
            end
        end
        for (int b = 0; b < tc.blocks; b++) begin
            for (int k = 0; k < matmul_pkg::slices; k++) begin
                blk_w[k] = make_weight(tc.w_mode, tc.w_val);
                blk_a[k] = make_act(tc.a_mode, tc.a_val, k);
            end
            for (int k = 0; k < matmul_pkg::slices; k++) begin
                weight_in = blk_w[k];
                act_in = blk_a[k];
                @(negedge clk);
            end
            for (int i = 0; i < matmul_pkg::rows; i++) begin
                halves = weight_halves(int'(blk_w[i / 3]), i % 3);
                for (int j = 0; j < matmul_pkg::slices; j++) begin
                    model[i][j] += scaled_term(halves, int'(blk_a[j]));
                end
            end
        end
        for (int i = 0; i < matmul_pkg::rows; i++) begin
            for (int j = 0; j < matmul_pkg::slices; j++) begin
                word = model[i][j];
                expect_q.push_back(word[16:9]);
            end
        end
        if (tc.first_byte >= 0) begin
            word = model[0][0];
            check_equal(word[16:9], tc.first_byte, "model value of the first output byte");
        end
    endtask

    // returns on the falling edge that sees read_ack and opens a new block
    task automatic request_readout();
        weight_in = '0;
        act_in = '0;
        read_req = 1'b1;
        @(negedge clk);
        while (!read_ack) @(negedge clk);
        read_req = 1'b0;
    endtask

    // output monitor, handshake checks and cycle limit
    always @(posedge clk) begin
        logic [7:0] exp_byte;
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end else if (reset) begin
            prev_ack = 1'b0;
            prev_req = 1'b0;
            prev_valid = 1'b0;
        end else begin
            if (read_ack && !prev_ack) begin
                check_equal(prev_req, 1, "read_ack rose without read_req");
                ack_rise_cycle = cycles;
            end
            if (!read_ack && prev_ack) begin
                check_equal(prev_req, 0, "read_ack fell while read_req was high");
            end
            if (out_valid && !prev_valid) begin
                check_equal(cycles, ack_rise_cycle + 1, "cycle of the first valid byte");
                valid_run = 0;
            end
            if (out_valid && expect_q.size() == 0) begin
                $display("out_valid was high although no readout was pending");
                $display("Something failed");
                $fatal(1, "unexpected output byte");
            end else if (out_valid) begin
                exp_byte = expect_q.pop_front();
                check_equal(out_data, exp_byte,
                            $sformatf("output byte %0d", byte_index % matmul_pkg::queue_len));
                valid_run++;
                byte_index++;
            end
            if (!out_valid && prev_valid) begin
                check_equal(valid_run, matmul_pkg::queue_len, "length of the valid burst");
            end
            prev_ack = read_ack;
            prev_req = read_req;
            prev_valid = out_valid;
        end
    end

    initial begin
        reset = 1'b1;
        weight_in = '0;
        act_in = '0;
        read_req = 1'b0;
        errors = 0;
        cycles = 0;
        test_count = 0;
        ack_rise_cycle = -10;
        valid_run = 0;
        byte_index = 0;
        void'($urandom(32'h453a38fd));

        //       weights       activations    blocks  first byte
        add_test(w_fixed, 0,   a_fixed, 0,    0,      0);
        add_test(w_fixed, 122, a_col0, 127,   200,    8'h63);
        add_test(w_fixed, 148, a_odd, 0,      20,     -1);
        add_test(w_high, 0,    a_rand, 0,     40,     -1);
        add_test(w_rand, 0,    a_rand, 0,     400,    -1);
        // all weights -2 against -128 runs past the 18-bit range
        add_test(w_fixed, 244, a_fixed, -128, 600,    8'h2c);
        add_test(w_rand, 0,    a_rand, 0,     3,      -1);

        cycle_limit = 10 + 200;
        for (int t = 0; t < test_count; t++) begin
            cycle_limit += 4 * tests[t].blocks + 60;
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_equal(read_ack, 0, "read_ack after reset");
        check_equal(out_valid, 0, "out_valid after reset");

        // each test starts on the block that opens with read_ack
        for (int t = 0; t < test_count; t++) begin
            send_blocks(tests[t]);
            request_readout();
        end

        while (expect_q.size() != 0 || out_valid) @(negedge clk);
        @(negedge clk);
        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

/* sources.f */
common/matmul_pkg.sv
rtl/weight_unpack.sv
array/operand_buffer.sv
array/mac_array.sv
array/result_queue.sv
rtl/readout_ctrl.sv
rtl/matmul_top.sv
bench/matmul_tb.sv
